/* common/lite_soc_macros.svh */
// ====================
// Address map, RAM size and GPIO register offsets
// Included by the package, the bus decoder, the devices and the testbench
// ====================
`ifndef LITE_SOC_MACROS_SVH
`define LITE_SOC_MACROS_SVH

// On-chip RAM, 4 KB of 32-bit words
`define LITE_MEM_BYTES 4096
`define LITE_MEM_AW 10

// First byte address past the RAM
`define LITE_MEM_LIMIT 32'h0000_1000

// Address bit that selects the GPIO block
`define LITE_GPIO_SEL_BIT 16

// GPIO register byte offsets
`define LITE_GPIO_LED_OFS 32'h0000_0000
`define LITE_GPIO_BTN_OFS 32'h0000_0004

`endif

/* common/lite_soc_pkg.sv */
// ====================
// Bus and device request types shared by the bus, the devices and the testbench
// ====================
`include "lite_soc_macros.svh"

package lite_soc_pkg;

    // Word index into the RAM, also used for GPIO register select
    typedef logic [`LITE_MEM_AW-1:0] word_addr_t;

    // ====================
    // Request at a bus port
    // ====================
    typedef struct packed {
        // Byte address, word aligned
        logic [31:0] addr;
        logic [31:0] wdata;
        // One bit per byte lane
        logic [3:0]  wmask;
        // Set for a write
        logic        we;
    } bus_req_t;

    // ====================
    // Request as seen by a device
    // ====================
    typedef struct packed {
        word_addr_t  word_addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        we;
    } dev_req_t;

endpackage

/* system_bus/sysbus_arbiter.sv */
// ====================
// Bus arbiter for the instruction and data ports, one transaction at a time
// Data port wins a tie, gnt comes two cycles after an uncontended request
// ====================
`timescale 1ns/1ps

module sysbus_arbiter import lite_soc_pkg::*; (
    input  logic        clk,
    input  logic        RSTN,
    // Instruction port, read only
    input  logic        instr_req,
    input  logic [31:0] instr_addr,
    output logic        instr_gnt,
    // Data port
    input  logic        data_rd_req,
    input  logic        data_wr_req,
    input  bus_req_t    data_cmd,
    output logic        data_gnt,
    // Towards the decoder
    output logic        issue,
    output logic [31:0] sel_addr,
    output dev_req_t    sel_req
);

typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    RESPOND
} state_t;

state_t   state;
logic     data_owner;
logic     data_pick;
logic     take;
bus_req_t pick;

// ====================
// Request selection
// ====================
assign data_pick = data_rd_req | data_wr_req;

// Accept only from IDLE
assign take = (state == IDLE) && (data_pick || instr_req);

always_comb begin
    if (data_pick) begin
        pick = data_cmd;
        // Direction follows the request line
        pick.we = data_wr_req;
    end else begin
        // Fetch is always a plain word read
        pick.addr  = instr_addr;
        pick.wdata = '0;
        pick.wmask = '0;
        pick.we    = 1'b0;
    end
end

// ====================
// Transaction FSM
// ====================
always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) begin
        state      <= IDLE;
        data_owner <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                if (take) begin
                    state      <= ISSUE;
                    data_owner <= data_pick;
                end
            end
            ISSUE:   state <= RESPOND;
            RESPOND: state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

// Captured request, held for the whole transaction
always_ff @(posedge clk) begin
    if (take) begin
        sel_addr          <= pick.addr;
        sel_req.word_addr <= word_addr_t'(pick.addr >> 2);
        sel_req.wdata     <= pick.wdata;
        sel_req.wmask     <= pick.wmask;
        sel_req.we        <= pick.we;
    end
end

// Strobe to the decoder in cycle 1
assign issue = (state == ISSUE);

// Grant only the owning port, cycle 2
assign data_gnt  = (state == RESPOND) && data_owner;
assign instr_gnt = (state == RESPOND) && !data_owner;

endmodule

/* system_bus/sysbus_decoder.sv */
// ====================
// Address decode to RAM or GPIO and read data return mux
// Unmapped addresses complete and read zero
// ====================
`timescale 1ns/1ps
`include "lite_soc_macros.svh"

module sysbus_decoder import lite_soc_pkg::*; (
    input  logic        clk,
    input  logic        RSTN,
    input  logic        issue,
    input  logic [31:0] sel_addr,
    input  dev_req_t    sel_req,
    output logic [31:0] rsp_data,
    // RAM
    output logic        mem_en,
    input  logic [31:0] mem_rdata,
    // GPIO
    output logic        gpio_en,
    input  logic [31:0] gpio_rdata,
    // Shared device request
    output dev_req_t    dev_req
);

typedef enum logic [1:0] {
    SEL_NONE,
    SEL_MEM,
    SEL_GPIO
} dev_sel_t;

logic     gpio_hit;
logic     mem_hit;
dev_sel_t rsp_sel;

// ====================
// Address map
// ====================
// GPIO bit takes priority over the RAM range
assign gpio_hit = sel_addr[`LITE_GPIO_SEL_BIT];
assign mem_hit  = !gpio_hit && (sel_addr < `LITE_MEM_LIMIT);

// At most one strobe per issue
assign mem_en  = issue && mem_hit;
assign gpio_en = issue && gpio_hit;

// Both devices see the same request fields
assign dev_req = sel_req;

// ====================
// Read return
// ====================
// Remember the source for the return cycle, writes return nothing
always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) begin
        rsp_sel <= SEL_NONE;
    end else if (issue) begin
        if (sel_req.we) rsp_sel <= SEL_NONE;
        else if (gpio_hit) rsp_sel <= SEL_GPIO;
        else if (mem_hit) rsp_sel <= SEL_MEM;
        else rsp_sel <= SEL_NONE;
    end
end

always_comb begin
    case (rsp_sel)
        SEL_MEM:  rsp_data = mem_rdata;
        SEL_GPIO: rsp_data = gpio_rdata;
        default:  rsp_data = '0;
    endcase
end

endmodule

/* verilog/ebr_memory.sv */
// ====================
// Synchronous word RAM with per-byte write enables, one cycle read latency
// ====================
`timescale 1ns/1ps
`include "lite_soc_macros.svh"

module ebr_memory import lite_soc_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  dev_req_t    req,
    output logic [31:0] rdata
);

localparam int WORDS = `LITE_MEM_BYTES / 4;

// Word storage
logic [31:0] mem [WORDS];

// ====================
// Access port
// ====================
always_ff @(posedge clk) begin
    if (en) begin
        if (req.we) begin
            // Only the enabled byte lanes change
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem[req.word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end else begin
            rdata <= mem[req.word_addr];
        end
    end
end

endmodule

/* verilog/gpio_regs.sv */
// ====================
// Memory-mapped LED and button registers, LED pin is active low
// ====================
`timescale 1ns/1ps
`include "lite_soc_macros.svh"

module gpio_regs import lite_soc_pkg::*; (
    input  logic        clk,
    input  logic        RSTN,
    input  logic        en,
    input  dev_req_t    req,
    input  logic        btn,
    output logic [31:0] rdata,
    output logic        ledg
);

// Register word indices within the block
localparam word_addr_t LED_IDX = word_addr_t'(`LITE_GPIO_LED_OFS >> 2);
localparam word_addr_t BTN_IDX = word_addr_t'(`LITE_GPIO_BTN_OFS >> 2);

logic       led_q;
logic [1:0] btn_sync;

// Button is asynchronous to clk
always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) btn_sync <= '0;
    else btn_sync <= {btn_sync[0], btn};
end

// LED register, off after reset
always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) begin
        led_q <= 1'b0;
    end else if (en && req.we && req.wmask[0] && (req.word_addr == LED_IDX)) begin
        led_q <= req.wdata[0];
    end
end

// Read port, value in bit 0
always_ff @(posedge clk) begin
    if (en && !req.we) begin
        case (req.word_addr)
            LED_IDX: rdata <= {31'b0, led_q};
            BTN_IDX: rdata <= {31'b0, btn_sync[1]};
            default: rdata <= '0;
        endcase
    end
end

// Pin drives low to light the LED
assign ledg = ~led_q;

endmodule

/* verilog/lite_soc_top.sv */
// ====================
// SoC top level with reset sync, system bus, 4 KB RAM and GPIO
// Instruction and data ports are driven by an external processor
// ====================
`timescale 1ns/1ps

module lite_soc_top import lite_soc_pkg::*; (
    input  logic        clk,
    input  logic        RSTN,
    // Instruction port
    input  logic        instr_req,
    input  logic [31:0] instr_addr,
    output logic        instr_gnt,
    output logic [31:0] instr_data,
    // Data port
    input  logic        data_rd_req,
    input  logic        data_wr_req,
    input  bus_req_t    data_cmd,
    output logic        data_gnt,
    output logic [31:0] data_rd_data,
    // Pins
    input  logic        btn,
    output logic        ledg
);

logic [1:0]  reset_sync;
logic        rstn_sync;
logic        issue;
logic [31:0] sel_addr;
dev_req_t    sel_req;
dev_req_t    dev_req;
logic [31:0] rsp_data;
logic        mem_en;
logic [31:0] mem_rdata;
logic        gpio_en;
logic [31:0] gpio_rdata;

// ====================
// Reset
// ====================
// Async assert, release synchronised to clk
always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) reset_sync <= '0;
    else reset_sync <= {reset_sync[0], 1'b1};
end
assign rstn_sync = reset_sync[1];

// ====================
// System bus
// ====================
sysbus_arbiter i_sysbus_arbiter (
    .clk        (clk        ),
    .RSTN       (rstn_sync  ),
    .instr_req  (instr_req  ),
    .instr_addr (instr_addr ),
    .instr_gnt  (instr_gnt  ),
    .data_rd_req(data_rd_req),
    .data_wr_req(data_wr_req),
    .data_cmd   (data_cmd   ),
    .data_gnt   (data_gnt   ),
    .issue      (issue      ),
    .sel_addr   (sel_addr   ),
    .sel_req    (sel_req    )
);

sysbus_decoder i_sysbus_decoder (
    .clk       (clk       ),
    .RSTN      (rstn_sync ),
    .issue     (issue     ),
    .sel_addr  (sel_addr  ),
    .sel_req   (sel_req   ),
    .rsp_data  (rsp_data  ),
    .mem_en    (mem_en    ),
    .mem_rdata (mem_rdata ),
    .gpio_en   (gpio_en   ),
    .gpio_rdata(gpio_rdata),
    .dev_req   (dev_req   )
);

// Both ports read from the one return path, only the granted port samples it
assign instr_data   = rsp_data;
assign data_rd_data = rsp_data;

// ====================
// Devices
// ====================
ebr_memory i_ebr_memory (
    .clk  (clk      ),
    .en   (mem_en   ),
    .req  (dev_req  ),
    .rdata(mem_rdata)
);

gpio_regs i_gpio_regs (
    .clk  (clk       ),
    .RSTN (rstn_sync ),
    .en   (gpio_en   ),
    .req  (dev_req   ),
    .btn  (btn       ),
    .rdata(gpio_rdata),
    .ledg (ledg      )
);

endmodule

/* testbench/tb_lite_soc.sv */
// ====================
// Directed testbench for the SoC top level, standing in for the processor
// Drives instruction and data ports, checks against a reference RAM model
// ====================
`timescale 1ns/1ps
`include "lite_soc_macros.svh"

module tb_lite_soc import lite_soc_pkg::*; ();

localparam int WORDS       = `LITE_MEM_BYTES / 4;
localparam int GNT_TIMEOUT = 20;
localparam logic [31:0] GPIO_BASE = 32'h1 << `LITE_GPIO_SEL_BIT;

logic        clk;
logic        RSTN;
logic        instr_req;
logic [31:0] instr_addr;
logic        instr_gnt;
logic [31:0] instr_data;
logic        data_rd_req;
logic        data_wr_req;
bus_req_t    data_cmd;
logic        data_gnt;
logic [31:0] data_rd_data;
logic        btn;
logic        ledg;

int          errors;
int          checks;
// Expected RAM contents
logic [31:0] ref_mem [WORDS];

lite_soc_top i_lite_soc_top (
    .clk         (clk         ),
    .RSTN        (RSTN        ),
    .instr_req   (instr_req   ),
    .instr_addr  (instr_addr  ),
    .instr_gnt   (instr_gnt   ),
    .instr_data  (instr_data  ),
    .data_rd_req (data_rd_req ),
    .data_wr_req (data_wr_req ),
    .data_cmd    (data_cmd    ),
    .data_gnt    (data_gnt    ),
    .data_rd_data(data_rd_data),
    .btn         (btn         ),
    .ledg        (ledg        )
);

// 20 ns clock
initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// ====================
// Helpers
// ====================
task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
endtask

// Poll at the falling edge, where gnt and read data are settled
task automatic wait_gnt(input bit data_port, input string name,
                        output logic [31:0] rdata, output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    rdata  = '0;
    while (!seen && cycles < GNT_TIMEOUT) begin
        @(negedge clk);
        if (data_port ? data_gnt : instr_gnt) begin
            seen  = 1'b1;
            rdata = data_port ? data_rd_data : instr_data;
        end else begin
            cycles++;
        end
    end
    if (!seen) begin
        errors++;
        $display("%s: no grant within %0d cycles", name, GNT_TIMEOUT);
    end
    // Caller releases req just after the grant edge
    @(posedge clk);
    #2;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wmask, input string name);
    logic [31:0] unused;
    int          cycles;
    @(posedge clk);
    #2;
    data_cmd    = '{addr: addr, wdata: wdata, wmask: wmask, we: 1'b1};
    data_wr_req = 1'b1;
    wait_gnt(1'b1, name, unused, cycles);
    data_wr_req = 1'b0;
    // Reference follows the enabled byte lanes, RAM range only
    if (!addr[`LITE_GPIO_SEL_BIT] && addr < `LITE_MEM_LIMIT) begin
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) ref_mem[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
        end
    end
endtask

task automatic bus_read(input logic [31:0] addr, input string name,
                        output logic [31:0] rdata);
    int cycles;
    @(posedge clk);
    #2;
    data_cmd    = '{addr: addr, wdata: '0, wmask: '0, we: 1'b0};
    data_rd_req = 1'b1;
    wait_gnt(1'b1, name, rdata, cycles);
    data_rd_req = 1'b0;
endtask

// ====================
// Tests
// ====================
task automatic word_write_read();
    logic [31:0] addrs [8];
    logic [31:0] rdata;
    compare_value("ledg after reset", 32'd1, {31'b0, ledg});
    for (int i = 0; i < 8; i++) begin
        addrs[i] = ($urandom % WORDS) << 2;
        bus_write(addrs[i], $urandom, 4'hf, "word_write");
    end
    for (int i = 0; i < 8; i++) begin
        bus_read(addrs[i], "word_read", rdata);
        compare_value($sformatf("word_read %0d", i), ref_mem[addrs[i][11:2]], rdata);
    end
endtask

task automatic byte_mask_write();
    logic [31:0] addr;
    logic [31:0] rdata;
    for (int i = 0; i < 6; i++) begin
        addr = ($urandom % WORDS) << 2;
        // Known base word, then a partial overwrite
        bus_write(addr, $urandom, 4'hf, "mask_base");
        bus_write(addr, $urandom, 4'($urandom), "mask_write");
        bus_read(addr, "mask_read", rdata);
        compare_value($sformatf("byte_mask %0d", i), ref_mem[addr[11:2]], rdata);
    end
endtask

task automatic fetch_after_write();
    logic [31:0] addr;
    logic [31:0] rdata;
    int          cycles;
    addr = ($urandom % WORDS) << 2;
    bus_write(addr, $urandom, 4'hf, "fetch_setup");
    @(posedge clk);
    #2;
    instr_addr = addr;
    instr_req  = 1'b1;
    wait_gnt(1'b0, "fetch", rdata, cycles);
    instr_req  = 1'b0;
    compare_value("fetch data", ref_mem[addr[11:2]], rdata);
    // Uncontended: taken at the next edge, grant two cycles on
    compare_value("fetch latency", 32'd2, cycles);
endtask

task automatic led_and_button();
    logic [31:0] rdata;
    bus_write(GPIO_BASE + `LITE_GPIO_LED_OFS, 32'd1, 4'hf, "led_on");
    compare_value("ledg on", 32'd0, {31'b0, ledg});
    bus_read(GPIO_BASE + `LITE_GPIO_LED_OFS, "led_read", rdata);
    compare_value("led readback 1", 32'd1, rdata);
    bus_write(GPIO_BASE + `LITE_GPIO_LED_OFS, 32'd0, 4'hf, "led_off");
    compare_value("ledg off", 32'd1, {31'b0, ledg});
    bus_read(GPIO_BASE + `LITE_GPIO_LED_OFS, "led_read", rdata);
    compare_value("led readback 0", 32'd0, rdata);
    // Two sync flops ahead of the register
    btn = 1'b1;
    repeat (4) @(posedge clk);
    bus_read(GPIO_BASE + `LITE_GPIO_BTN_OFS, "btn_read", rdata);
    compare_value("button high", 32'd1, rdata);
    btn = 1'b0;
    repeat (4) @(posedge clk);
    bus_read(GPIO_BASE + `LITE_GPIO_BTN_OFS, "btn_read", rdata);
    compare_value("button low", 32'd0, rdata);
endtask

task automatic concurrent_ports();
    logic [31:0] addr_d;
    logic [31:0] addr_i;
    logic [31:0] data_word;
    logic [31:0] instr_word;
    int          data_at;
    int          instr_at;
    addr_d   = ($urandom % WORDS) << 2;
    addr_i   = addr_d ^ 32'h0000_0004;
    data_at  = -1;
    instr_at = -1;
    bus_write(addr_d, $urandom, 4'hf, "tie_setup_d");
    bus_write(addr_i, $urandom, 4'hf, "tie_setup_i");
    @(posedge clk);
    #2;
    data_cmd    = '{addr: addr_d, wdata: '0, wmask: '0, we: 1'b0};
    data_rd_req = 1'b1;
    instr_addr  = addr_i;
    instr_req   = 1'b1;
    // Both ports polled together, each dropped after its own grant
    for (int i = 0; i < GNT_TIMEOUT && (data_at < 0 || instr_at < 0); i++) begin
        @(negedge clk);
        if (data_gnt) begin
            data_at   = i;
            data_word = data_rd_data;
        end
        if (instr_gnt) begin
            instr_at   = i;
            instr_word = instr_data;
        end
        @(posedge clk);
        #2;
        if (data_at >= 0) data_rd_req = 1'b0;
        if (instr_at >= 0) instr_req = 1'b0;
    end
    data_rd_req = 1'b0;
    instr_req   = 1'b0;
    if (data_at < 0 || instr_at < 0) begin
        errors++;
        $display("concurrent_ports: both ports not granted within %0d cycles", GNT_TIMEOUT);
    end else begin
        compare_value("tie data word", ref_mem[addr_d[11:2]], data_word);
        compare_value("tie instr word", ref_mem[addr_i[11:2]], instr_word);
        compare_value("tie data first", 32'd1, {31'b0, data_at < instr_at});
    end
endtask

task automatic unmapped_read();
    logic [31:0] rdata;
    // Above the RAM, GPIO bit clear
    bus_read(32'h0000_2000, "unmapped_read", rdata);
    compare_value("unmapped 0x2000", 32'd0, rdata);
    bus_read(32'h0000_fffc, "unmapped_read", rdata);
    compare_value("unmapped 0xfffc", 32'd0, rdata);
endtask

// ====================
// Main sequence
// ====================
initial begin
    errors      = 0;
    checks      = 0;
    void'($urandom(32'h75e1_b77f));
    RSTN        = 1'b0;
    instr_req   = 1'b0;
    instr_addr  = '0;
    data_rd_req = 1'b0;
    data_wr_req = 1'b0;
    data_cmd    = '0;
    btn         = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    RSTN = 1'b1;
    // Reset synchroniser release
    repeat (4) @(posedge clk);
    word_write_read();
    byte_mask_write();
    fetch_after_write();
    led_and_button();
    concurrent_ports();
    unmapped_read();
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

/* tb.f */
+incdir+common
common/lite_soc_pkg.sv
system_bus/sysbus_arbiter.sv
system_bus/sysbus_decoder.sv
verilog/ebr_memory.sv
verilog/gpio_regs.sv
verilog/lite_soc_top.sv
testbench/tb_lite_soc.sv

/* Makefile */
# Verilator build and run of the SoC testbench
VERILATOR ?= verilator
TOP       ?= tb_lite_soc
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
